/* testbench/rename_vectors.txt */
# mask free commit redir(1s=start s) win0..win7(rrssdd) count|stall slot0..3(V TT UU C)
# tags: 2c pending on station c, otherwise the real register
# idle after reset
00 04 0000 00 000000 000000 000000 000000 000000 000000 000000 000000 00 000000 000000 000000 000000
# sparse window, in-group bypass
4a 10 0000 00 000000 010205 000000 050006 000000 000000 060505 000000 30 000000 000000 000000 000000
0f 10 0000 00 050607 000700 070505 050008 000000 000000 000000 000000 40 101020 120001 121202 000000
# commit of stations 1 and 5 on entry
03 10 0022 00 060509 080700 000000 000000 000000 000000 000000 000000 20 122213 100234 123225 125006
# stall, held tags follow commits of 3 and 6
f0 03 0000 00 000000 000000 000000 000000 08090a 0a070b 010203 090000 01 000000 000000 000000 000000
f0 03 0048 00 000000 000000 000000 000000 08090a 0a070b 010203 090000 01 000000 000000 000000 000000
f0 04 0000 00 000000 000000 000000 000000 08090a 0a070b 010203 090000 40 106057 108078 000000 000000
# pointer wraps 15 to 0
a5 10 0000 00 030a0c 000000 0c0b0d 000000 000000 0d0c0c 000000 0c0d0e 40 108279 12907a 10102b 12700c
03 10 8200 00 0a0c0c 0c0e0f 000000 000000 000000 000000 000000 000000 20 12b29d 12d2ae 12e2df 12f2e0
# redirect to station a, then two reload cycles
01 10 0000 1a 0c0d05 000000 000000 000000 000000 000000 000000 000000 10 10a0c1 121202 000000 000000
0f 10 0000 00 0b0d01 0e0f02 030900 010203 000000 000000 000000 000000 00 000000 000000 000000 000000
0f 10 0000 00 0b0d01 0e0f02 030900 010203 000000 000000 000000 000000 00 000000 000000 000000 000000
0f 10 0000 00 0b0d01 0e0f02 030900 010203 000000 000000 000000 000000 40 000000 000000 000000 000000
00 02 0000 00 000000 000000 000000 000000 000000 000000 000000 000000 00 10b0da 10e0fb 10309c 12a2bd
# single entry, exact free count
80 01 0400 00 000000 000000 000000 000000 000000 000000 000000 030104 10 000000 000000 000000 000000
# stall on one free station, then release
11 01 0000 00 040206 000000 000000 000000 060007 000000 000000 000000 01 000000 000000 000000 000000
11 02 2000 00 040206 000000 000000 000000 060007 000000 000000 000000 20 12d01e 000000 000000 000000
00 05 0000 00 000000 000000 000000 000000 000000 000000 000000 000000 00 12e2bf 12f000 000000 000000
00 05 0000 00 000000 000000 000000 000000 000000 000000 000000 000000 00 000000 000000 000000 000000

/* rename_stage.f */
hdl/rename_pkg.sv
hdl/rename_ctrl.sv
hdl/rename_scoreboard.sv
hdl/rename_select.sv
hdl/rename_slot.sv
hdl/rename_stage.sv
testbench/rename_stage_props.sv
testbench/tb_rename_stage.sv

/* run_verilator.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rename_stage \
	-f rename_stage.f \
	-o tb_rename_stage

./obj_dir/tb_rename_stage

/* testbench/tb_rename_stage.sv */
// rename stage testbench
module tb_rename_stage import rename_pkg::*; ();

	localparam logic [31:0] SEED = 32'h5c359f50;
	localparam int TIMEOUT_MARGIN = 20;
	localparam string VEC_FILE = "testbench/rename_vectors.txt";
	localparam int MAX_VEC = 64;
	localparam int NFIELD = 17;

	logic clk;
	logic reset;
	logic [NWIN-1:0] dec_valid;
	dec_inst_t dec_inst [NWIN];
	logic [LNCOMMIT:0] free_count;
	logic [NCOMMIT-1:0] commit_done;
	logic redirect;
	cs_idx_t redirect_start;
	ren_inst_t ren_out [NDEC];
	cnt_t rename_count;
	logic rename_stall;
	logic rename_reloading;

	// one row per cycle, columns as in the vector file
	logic [31:0] vec [MAX_VEC][NFIELD];
	int nvec = 0;
	int held_vec = 0;
	int cycles = 0;
	int limit = TIMEOUT_MARGIN;

	rename_stage rename_stage_i (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_inst(dec_inst),
		.free_count(free_count),
		.commit_done(commit_done),
		.redirect(redirect),
		.redirect_start(redirect_start),
		.ren_out(ren_out),
		.rename_count(rename_count),
		.rename_stall(rename_stall),
		.rename_reloading(rename_reloading)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Test failed");
			$fatal(1, "run did not finish within %0d cycles", limit);
		end
	end

	// rrssdd word, rs2 and rd count as used unless they are x0
	function automatic dec_inst_t unpack_inst(input logic [31:0] w);
		dec_inst_t d;
		d.rs1 = w[20:16];
		d.rs2 = w[12:8];
		d.rd = w[4:0];
		d.needs_rs2 = (w[12:8] != '0);
		d.makes_rd = (w[4:0] != '0);
		return d;
	endfunction

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [31:0] f [NFIELD];
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Test failed");
			$fatal(1, "cannot open vector file %s", VEC_FILE);
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
			if (n != NFIELD || nvec >= MAX_VEC) begin
				$display("Test failed");
				$fatal(1, "malformed or extra vector line: %s", line);
			end
			vec[nvec] = f;
			nvec++;
		end
		$fclose(fd);
	endtask

	task automatic drive_vector(input int i);
		dec_valid = vec[i][0][NWIN-1:0];
		free_count = vec[i][1][LNCOMMIT:0];
		// stall cannot depend on free_count with an empty window
		if (vec[i][0] == 0)
			free_count = (LNCOMMIT+1)'($urandom_range(NCOMMIT, 0));
		commit_done = vec[i][2][NCOMMIT-1:0];
		redirect = vec[i][3][4];
		redirect_start = vec[i][3][3:0];
		for (int k = 0; k < NWIN; k++)
			dec_inst[k] = unpack_inst(vec[i][4+k]);
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_vector(input int i);
		logic [31:0] w;
		logic [31:0] grp [NDEC];
		int n;
		// last accepted group, valid entries in window order
		n = 0;
		for (int j = 0; j < NWIN; j++) begin
			if (vec[held_vec][0][j] && n < NDEC) begin
				grp[n] = vec[held_vec][4+j];
				n++;
			end
		end
		expect_eq("rename_count", 32'(rename_count), 32'(vec[i][12][7:4]));
		expect_eq("rename_stall", 32'(rename_stall), 32'(vec[i][12][0]));
		for (int k = 0; k < NDEC; k++) begin
			w = vec[i][13+k];
			expect_eq($sformatf("ren_out[%0d].valid", k), 32'(ren_out[k].valid), 32'(w[20]));
			// fields of an invalid slot are don't care
			if (w[20]) begin
				expect_eq($sformatf("ren_out[%0d].rs1_tag", k),
					32'(ren_out[k].rs1_tag), 32'(w[17:12]));
				expect_eq($sformatf("ren_out[%0d].rs2_tag", k),
					32'(ren_out[k].rs2_tag), 32'(w[9:4]));
				expect_eq($sformatf("ren_out[%0d].rd_cs", k),
					32'(ren_out[k].rd_cs), 32'(w[3:0]));
				expect_eq($sformatf("ren_out[%0d].{rd,makes_rd,needs_rs2}", k),
					32'({ren_out[k].rd, ren_out[k].makes_rd, ren_out[k].needs_rs2}),
					32'({grp[k][4:0], grp[k][4:0] != 5'h0, grp[k][12:8] != 5'h0}));
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		dec_valid = '0;
		free_count = '0;
		commit_done = '0;
		redirect = 1'b0;
		redirect_start = '0;
		for (int k = 0; k < NWIN; k++)
			dec_inst[k] = '0;
		load_vectors();
		limit = nvec + TIMEOUT_MARGIN;
		repeat (4) @(posedge clk);
		for (int i = 0; i < nvec; i++) begin
			#1;
			reset = 1'b0;
			drive_vector(i);
			#8;
			check_vector(i);
			if (vec[i][12][7:4] != 0)
				held_vec = i;
			@(posedge clk);
		end
		$display("Test passed");
		$finish;
	end

endmodule

/* testbench/rename_stage_props.sv */
// rename stage assertions
module rename_stage_props import rename_pkg::*; (
	input logic clk,
	input logic reset,
	input logic redirect,
	input logic rename_stall,
	input logic rename_reloading,
	input cnt_t rename_count,
	input ren_inst_t ren_out [NDEC]
);

	logic [NDEC-1:0] out_valid;

	always_comb begin
		for (int k = 0; k < NDEC; k++)
			out_valid[k] = ren_out[k].valid;
	end

	stall_no_count: assert property (@(posedge clk) disable iff (reset)
		rename_stall |-> rename_count == '0)
		else $error("rename count nonzero while stalled");

	reload_no_valid: assert property (@(posedge clk) disable iff (reset)
		rename_reloading |-> out_valid == '0)
		else $error("valid output while reloading");

	// bubble is two cycles long
	redirect_reload: assert property (@(posedge clk) disable iff (reset)
		redirect |=> rename_reloading [*2])
		else $error("redirect not followed by two reload cycles");

	reset_no_valid: assert property (@(posedge clk)
		reset |=> out_valid == '0)
		else $error("valid output right after reset");

endmodule

bind rename_stage rename_stage_props props_i (
	.clk(clk),
	.reset(reset),
	.redirect(redirect),
	.rename_stall(rename_stall),
	.rename_reloading(rename_reloading),
	.rename_count(rename_count),
	.ren_out(ren_out)
);

/* hdl/rename_stage.sv */
// register rename stage
module rename_stage import rename_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [NWIN-1:0] dec_valid,
	input  dec_inst_t dec_inst [NWIN],
	input  logic [LNCOMMIT:0] free_count,
	input  logic [NCOMMIT-1:0] commit_done,
	input  logic redirect,
	input  cs_idx_t redirect_start,
	output ren_inst_t ren_out [NDEC],
	output cnt_t rename_count,
	output logic rename_stall,
	output logic rename_reloading
);

	cs_idx_t next_start;
	logic accept;
	dec_inst_t group [NDEC];
	logic [NDEC-1:0] group_hit;
	sb_table_t sb_table;

	// group is taken whole or not at all
	assign accept = !reset && !rename_reloading && !rename_stall;

	rename_ctrl ctrl_i (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.free_count(free_count),
		.redirect(redirect),
		.redirect_start(redirect_start),
		.next_start(next_start),
		.rename_count(rename_count),
		.rename_stall(rename_stall),
		.rename_reloading(rename_reloading)
	);

	rename_scoreboard scoreboard_i (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.redirect(redirect),
		.group(group),
		.group_hit(group_hit),
		.next_start(next_start),
		.commit_done(commit_done),
		.sb_table(sb_table)
	);

	for (genvar k = 0; k < NDEC; k++) begin : g_slot
		rename_select #(.SLOT(k)) select_i (
			.dec_valid(dec_valid),
			.dec_inst(dec_inst),
			.sel_inst(group[k]),
			.hit(group_hit[k])
		);

		rename_slot #(.SLOT(k)) slot_i (
			.clk(clk),
			.reset(reset),
			.group(group),
			.group_hit(group_hit),
			.sb_table(sb_table),
			.next_start(next_start),
			.commit_done(commit_done),
			.accept(accept),
			.redirect(redirect),
			.rename_stall(rename_stall),
			.rename_reloading(rename_reloading),
			.ren_out(ren_out[k])
		);
	end

endmodule

/* hdl/rename_slot.sv */
// rename slot
module rename_slot import rename_pkg::*; #(
	parameter int SLOT = 0
) (
	input  logic clk,
	input  logic reset,
	input  dec_inst_t group [NDEC],
	input  logic [NDEC-1:0] group_hit,
	input  sb_table_t sb_table,
	input  cs_idx_t next_start,
	input  logic [NCOMMIT-1:0] commit_done,
	input  logic accept,
	input  logic redirect,
	input  logic rename_stall,
	input  logic rename_reloading,
	output ren_inst_t ren_out
);

	arch_reg_t src [2];
	reg_tag_t src_tag [2];
	ren_inst_t r_out;

	// real source registers, needed to retire held tags
	arch_reg_t r_rs1;
	arch_reg_t r_rs2;

	// pending tag whose station is done turns into the real register
	function automatic reg_tag_t settle(
		input reg_tag_t tag,
		input arch_reg_t areg,
		input logic [NCOMMIT-1:0] done
	);
		reg_tag_t res;
		res = tag;
		if (tag.pend.pending && done[tag.pend.cs])
			res.arch = '{pending: 1'b0, areg: areg};
		return res;
	endfunction

	assign src[0] = group[SLOT].rs1;
	assign src[1] = group[SLOT].rs2;

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			if (src[s] == '0) begin
				src_tag[s] = '0;
			end else begin
				src_tag[s] = sb_table[src[s]];
				// latest earlier writer in this group overrides the table
				for (int k = 0; k < SLOT; k++) begin
					if (group_hit[k] && group[k].makes_rd && group[k].rd == src[s])
						src_tag[s].pend = '{
							pending: 1'b1,
							spare: '0,
							cs: next_start + cs_idx_t'(k)
						};
				end
				src_tag[s] = settle(src_tag[s], src[s], commit_done);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			r_out.rs1_tag <= src_tag[0];
			r_out.rs2_tag <= src_tag[1];
			r_out.rd_cs <= next_start + cs_idx_t'(SLOT);
			r_out.rd <= group[SLOT].rd;
			r_out.makes_rd <= group[SLOT].makes_rd;
			r_out.needs_rs2 <= group[SLOT].needs_rs2;
			r_rs1 <= src[0];
			r_rs2 <= src[1];
		end else if (rename_stall) begin
			// held group keeps tracking commits
			r_out.rs1_tag <= settle(r_out.rs1_tag, r_rs1, commit_done);
			r_out.rs2_tag <= settle(r_out.rs2_tag, r_rs2, commit_done);
		end

		// group caught by a redirect is wrong path
		if (reset || redirect)
			r_out.valid <= 1'b0;
		else if (accept)
			r_out.valid <= group_hit[SLOT];
	end

	always_comb begin
		ren_out = r_out;
		ren_out.valid = r_out.valid && !rename_stall && !rename_reloading;
	end

endmodule

/* hdl/rename_select.sv */
// nth valid decode entry select
module rename_select import rename_pkg::*; #(
	parameter int SLOT = 0
) (
	input  logic [NWIN-1:0] dec_valid,
	input  dec_inst_t dec_inst [NWIN],
	output dec_inst_t sel_inst,
	output logic hit
);

	logic [NWIN-1:0] onehot;

	// mark the entry with exactly SLOT valid entries below it
	always_comb begin
		int seen;
		seen = 0;
		onehot = '0;
		for (int i = 0; i < NWIN; i++) begin
			if (dec_valid[i]) begin
				if (seen == SLOT)
					onehot[i] = 1'b1;
				seen++;
			end
		end
	end

	assign hit = |onehot;

	// one hot mux, zero when there is no hit
	always_comb begin
		sel_inst = '0;
		for (int i = 0; i < NWIN; i++) begin
			if (onehot[i])
				sel_inst = dec_inst[i];
		end
	end

endmodule

/* hdl/rename_scoreboard.sv */
// latest rename scoreboard
module rename_scoreboard import rename_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic accept,
	input  logic redirect,
	input  dec_inst_t group [NDEC],
	input  logic [NDEC-1:0] group_hit,
	input  cs_idx_t next_start,
	input  logic [NCOMMIT-1:0] commit_done,
	output sb_table_t sb_table
);

	sb_table_t sb_next;

	always_comb begin
		sb_next = sb_table;

		// producer has written back, read the real register again
		for (int r = 1; r < NARCH; r++) begin
			if (sb_table[r].pend.pending && commit_done[sb_table[r].pend.cs])
				sb_next[r].arch = '{pending: 1'b0, areg: arch_reg_t'(r)};
		end

		// new writers override any commit in the same cycle
		// later slots overwrite earlier ones
		if (accept) begin
			for (int k = 0; k < NDEC; k++) begin
				if (group_hit[k] && group[k].makes_rd && group[k].rd != '0)
					sb_next[group[k].rd].pend = '{
						pending: 1'b1,
						spare: '0,
						cs: next_start + cs_idx_t'(k)
					};
			end
		end
	end

	// stations are discarded on a redirect so every register reads real
	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			for (int r = 1; r < NARCH; r++)
				sb_table[r].arch <= '{pending: 1'b0, areg: arch_reg_t'(r)};
		end else begin
			sb_table <= sb_next;
		end
	end

endmodule

/* hdl/rename_ctrl.sv */
// rename controller
module rename_ctrl import rename_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [NWIN-1:0] dec_valid,
	input  logic [LNCOMMIT:0] free_count,
	input  logic redirect,
	input  cs_idx_t redirect_start,
	output cs_idx_t next_start,
	output cnt_t rename_count,
	output logic rename_stall,
	output logic rename_reloading
);

	cnt_t count;
	logic [1:0] reload_sr;

	// valid entries in the window, capped at one group
	always_comb begin
		int total;
		total = 0;
		for (int i = 0; i < NWIN; i++) begin
			if (dec_valid[i])
				total++;
		end
		count = cnt_t'((total > NDEC) ? NDEC : total);
	end

	// not enough free stations for the whole group
	assign rename_stall = (LNCOMMIT+1)'(count) > free_count;

	assign rename_count = (reset || rename_reloading || rename_stall) ? '0 : count;

	// allocation pointer wraps naturally at NCOMMIT
	always_ff @(posedge clk) begin
		if (reset)
			next_start <= '0;
		else if (redirect)
			next_start <= redirect_start;
		else
			next_start <= next_start + cs_idx_t'(rename_count);
	end

	// two cycle bubble while fetch and decode refill
	always_ff @(posedge clk) begin
		if (reset)
			reload_sr <= '0;
		else
			reload_sr <= {reload_sr[0], redirect};
	end

	assign rename_reloading = |reload_sr;

endmodule

/* hdl/rename_pkg.sv */
// rename stage shared types
package rename_pkg;

	// group and window sizes
	localparam int NDEC = 4;
	localparam int NWIN = 2 * NDEC;

	// commit stations
	localparam int NCOMMIT = 16;
	localparam int LNCOMMIT = 4;

	// real registers and operand tags
	localparam int NARCH = 32;
	localparam int RA = 5;
	localparam int TAG_W = 6;

	typedef logic [LNCOMMIT-1:0] cs_idx_t;
	typedef logic [RA-1:0] arch_reg_t;

	// stations taken in one cycle, 0 to NDEC
	typedef logic [$clog2(NDEC+1)-1:0] cnt_t;

	// top bit set, waiting on a commit station
	typedef struct packed {
		logic pending;
		logic [TAG_W-LNCOMMIT-2:0] spare;
		cs_idx_t cs;
	} tag_pend_t;

	// top bit clear, value lives in the real register
	typedef struct packed {
		logic pending;
		arch_reg_t areg;
	} tag_arch_t;

	typedef union packed {
		tag_pend_t pend;
		tag_arch_t arch;
	} reg_tag_t;

	typedef struct packed {
		arch_reg_t rs1;
		arch_reg_t rs2;
		arch_reg_t rd;
		logic needs_rs2;
		logic makes_rd;
	} dec_inst_t;

	typedef struct packed {
		logic valid;
		reg_tag_t rs1_tag;
		reg_tag_t rs2_tag;
		cs_idx_t rd_cs;
		arch_reg_t rd;
		logic makes_rd;
		logic needs_rs2;
	} ren_inst_t;

	// one entry per real register, x0 has none
	typedef reg_tag_t [NARCH-1:1] sb_table_t;

endpackage
